// ==== src/obj_pkg.sv ====
`default_nettype none

package obj_pkg;

    // one object entry in the list
    localparam int obj_entry_words = 4;

    // word offsets inside an entry
    localparam int obj_wd_x    = 0;
    localparam int obj_wd_y    = 1;
    localparam int obj_wd_code = 2;
    localparam int obj_wd_attr = 3;

    // hard ceiling on entries walked per line
    localparam int obj_max_entries = 256;

    // top byte of the attribute word that closes the list
    localparam logic [7:0] obj_end_code = 8'hff;

    // video line counter width
    localparam int obj_line_w = 9;

    // attribute word, read either as a list marker or as object format
    typedef union packed {
        // marker view
        struct packed {
            logic [7:0] marker;
            logic [7:0] dc;
        } ctl;
        // format view
        struct packed {
            logic [3:0] vsize;   // height in 16-line steps, minus one
            logic [3:0] hsize;   // width in 16-pixel steps, minus one
            logic       rsvd;
            logic       flipy;
            logic       flipx;
            logic [4:0] palette;
        } fmt;
    } obj_attr_u;

endpackage

`default_nettype wire

// ==== src/obj_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_table #(
    parameter int table_aw = 10
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 vb,

    // VRAM side, cs held for the whole copy
    input  wire  [15:0]         vram_base,
    output logic [17:1]         vram_addr,
    input  wire  [15:0]         vram_data,
    input  wire                 vram_ok,
    output logic                vram_cs,

    // scanner read port
    input  wire  [table_aw-1:0] table_addr,
    output logic [15:0]         table_data
);

    localparam logic st_idle = 1'b0;
    localparam logic st_copy = 1'b1;

    logic                st;
    logic                bank_rd;
    logic                vb_l;
    logic                vb_fall;
    logic                wait_cycle;
    logic                take;
    logic [table_aw-1:0] wr_addr;

    // two banks, msb of the address picks the bank
    logic [15:0]         mem [0:2**(table_aw+1)-1];

    // end of blanking, one cycle after vb drops
    assign vb_fall = vb_l && !vb;

    // a word is accepted when VRAM answers on the held bus outside the wait cycle
    assign take = vram_cs && vram_ok && !wait_cycle;

    always_ff @(posedge clk) begin
        // write side goes to the bank not being read
        if (take) begin
            mem[{~bank_rd, wr_addr}] <= vram_data;
        end
        // registered read, one cycle latency
        table_data <= mem[{bank_rd, table_addr}];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= st_idle;
            bank_rd    <= 1'b0;
            vb_l       <= 1'b0;
            vram_cs    <= 1'b0;
            vram_addr  <= '0;
            wr_addr    <= '0;
            wait_cycle <= 1'b1;
        end else begin
            vb_l <= vb;
            case (st)
                st_idle: begin
                    if (vb_fall) begin
                        // freeze last copy for the scanner
                        bank_rd    <= ~bank_rd;
                        vram_cs    <= 1'b1;
                        vram_addr  <= {vram_base[9:1], 8'd0};
                        wr_addr    <= '0;
                        wait_cycle <= 1'b1;
                        st         <= st_copy;
                    end
                end
                st_copy: begin
                    // wait one cycle after every accepted word
                    wait_cycle <= take;
                    if (take) begin
                        vram_addr <= vram_addr + 17'd1;
                        wr_addr   <= wr_addr + 1'b1;
                        // last word of the bank, release the bus
                        if (&wr_addr) begin
                            vram_cs <= 1'b0;
                            st      <= st_idle;
                        end
                    end
                end
                default: begin
                    st <= st_idle;
                end
            endcase
        end
    end

    // idle machine never writes the table
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (st == st_idle) |-> !take);

    // address only moves at copy start or while the bus is held
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (!vram_cs && !vb_fall) |=> $stable(vram_addr));

endmodule

`default_nettype wire

// ==== src/obj_line_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_line_scan
    import obj_pkg::*;
#(
    parameter int table_aw    = 10,
    parameter int entry_limit = obj_max_entries
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   line_start,
    input  wire  [obj_line_w-1:0] line,

    // frozen table bank
    output logic [table_aw-1:0]   table_addr,
    input  wire  [15:0]           table_data,

    // hit object stream
    output logic                  obj_valid,
    input  wire                   obj_ready,
    output logic [15:0]           obj_x,
    output logic [15:0]           obj_code,
    output logic [15:0]           obj_attr,
    output logic [obj_line_w-1:0] obj_row,
    output logic                  line_done
);

    localparam int sel_w = $clog2(obj_entry_words);
    localparam int idx_w = table_aw - sel_w;
    localparam logic [idx_w-1:0] last_idx = idx_w'(entry_limit - 1);

    // one state per read slot, then evaluate and hold
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_attr = 3'd1;
    localparam logic [2:0] st_y    = 3'd2;
    localparam logic [2:0] st_x    = 3'd3;
    localparam logic [2:0] st_code = 3'd4;
    localparam logic [2:0] st_eval = 3'd5;
    localparam logic [2:0] st_hold = 3'd6;

    logic [2:0]            st;
    logic [idx_w-1:0]      idx;
    logic [sel_w-1:0]      word_sel;
    logic [obj_line_w-1:0] line_q;
    logic [obj_line_w-1:0] y_q;
    logic [obj_line_w-1:0] row;
    logic [obj_line_w-1:0] span;
    obj_attr_u             attr_in;
    obj_attr_u             attr_q;
    logic                  hit;
    logic                  step;

    // word requested in each slot, attribute first
    always_comb begin
        case (st)
            st_attr: word_sel = sel_w'(obj_wd_attr);
            st_y:    word_sel = sel_w'(obj_wd_y);
            st_x:    word_sel = sel_w'(obj_wd_x);
            st_code: word_sel = sel_w'(obj_wd_code);
            default: word_sel = sel_w'(obj_wd_attr);
        endcase
    end

    assign table_addr = {idx, word_sel};

    // data arriving now belongs to the previous slot
    assign attr_in = table_data;

    // row inside the object, wraps at 512
    assign row  = line_q - y_q;
    assign span = obj_line_w'({1'b0, attr_q.fmt.vsize} + 5'd1) << 4;
    assign hit  = row < span;

    // entry finished: missed, or hit handed over
    assign step = ((st == st_eval) && !hit) || ((st == st_hold) && obj_ready);

    assign obj_attr = attr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= st_idle;
            idx       <= '0;
            obj_valid <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (st)
                st_idle: begin
                    // new walk only from idle
                    if (line_start) begin
                        idx <= '0;
                        st  <= st_attr;
                    end
                end
                st_attr: begin
                    st <= st_y;
                end
                st_y: begin
                    // end marker closes the list
                    if (attr_in.ctl.marker == obj_end_code) begin
                        line_done <= 1'b1;
                        st        <= st_idle;
                    end else begin
                        st <= st_x;
                    end
                end
                st_x: begin
                    st <= st_code;
                end
                st_code: begin
                    st <= st_eval;
                end
                st_eval: begin
                    if (hit) begin
                        obj_valid <= 1'b1;
                        st        <= st_hold;
                    end
                end
                st_hold: begin
                    if (obj_ready) begin
                        obj_valid <= 1'b0;
                    end
                end
                default: begin
                    st <= st_idle;
                end
            endcase
            // next entry or stop at the limit
            if (step) begin
                if (idx == last_idx) begin
                    line_done <= 1'b1;
                    st        <= st_idle;
                end else begin
                    idx <= idx + 1'b1;
                    st  <= st_attr;
                end
            end
        end
    end

    // entry fields, loaded only while the stream is idle
    always_ff @(posedge clk) begin
        if ((st == st_idle) && line_start) begin
            line_q <= line;
        end
        if (st == st_y) begin
            attr_q <= attr_in;
        end
        if (st == st_x) begin
            y_q <= table_data[obj_line_w-1:0];
        end
        if (st == st_code) begin
            obj_x <= table_data;
        end
        if (st == st_eval) begin
            obj_code <= table_data;
            obj_row  <= row;
        end
    end

    // presented object stays put under back-pressure
    a_stream_hold: assert property (@(posedge clk) disable iff (rst)
        (obj_valid && !obj_ready) |=> obj_valid && $stable(obj_x) && $stable(obj_code)
            && $stable(obj_attr) && $stable(obj_row));

    // end of line only after the last hit has gone
    a_done_alone: assert property (@(posedge clk) disable iff (rst)
        line_done |-> !obj_valid);

endmodule

`default_nettype wire

// ==== src/obj_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_top
    import obj_pkg::*;
#(
    parameter int table_aw    = 10,
    parameter int entry_limit = 256
) (
    input  wire                   clk,
    input  wire                   rst,

    // video timing
    input  wire                   vb,
    input  wire                   line_start,
    input  wire  [obj_line_w-1:0] line,

    // VRAM
    input  wire  [15:0]           vram_base,
    input  wire  [15:0]           vram_data,
    input  wire                   vram_ok,
    output logic                  vram_cs,
    output logic [17:1]           vram_addr,

    // object stream
    output logic                  obj_valid,
    input  wire                   obj_ready,
    output logic [15:0]           obj_x,
    output logic [15:0]           obj_code,
    output logic [15:0]           obj_attr,
    output logic [obj_line_w-1:0] obj_row,
    output logic                  line_done
);

    // scanner to table read path
    logic [table_aw-1:0] table_addr;
    logic [15:0]         table_data;

    // copy engine and double-buffered list
    obj_table #(
        .table_aw   (table_aw)
    ) table_i (
        .clk        (clk),
        .rst        (rst),
        .vb         (vb),
        .vram_base  (vram_base),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .vram_cs    (vram_cs),
        .table_addr (table_addr),
        .table_data (table_data)
    );

    // per-line walker on the frozen bank
    obj_line_scan #(
        .table_aw    (table_aw),
        .entry_limit (entry_limit)
    ) scan_i (
        .clk         (clk),
        .rst         (rst),
        .line_start  (line_start),
        .line        (line),
        .table_addr  (table_addr),
        .table_data  (table_data),
        .obj_valid   (obj_valid),
        .obj_ready   (obj_ready),
        .obj_x       (obj_x),
        .obj_code    (obj_code),
        .obj_attr    (obj_attr),
        .obj_row     (obj_row),
        .line_done   (line_done)
    );

endmodule

`default_nettype wire

// ==== sim/obj_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_checker
    import obj_pkg::*;
#(
    parameter int entry_limit = obj_max_entries
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   vb,
    input  wire  [15:0]           vram_base,
    input  wire                   vram_cs,
    input  wire  [17:1]           vram_addr,
    input  wire  [15:0]           vram_data,
    input  wire                   vram_ok,
    input  wire                   line_start,
    input  wire  [obj_line_w-1:0] line,
    input  wire                   obj_valid,
    input  wire                   obj_ready,
    input  wire  [15:0]           obj_x,
    input  wire  [15:0]           obj_code,
    input  wire  [15:0]           obj_attr,
    input  wire  [obj_line_w-1:0] obj_row,
    input  wire                   line_done,
    output int                    value_errs,
    output int                    other_errs,
    output int                    objs_seen
);

    // list being captured, last complete copy, list the scanner walks
    logic [15:0]           capt [0:1023];
    logic [15:0]           copied [0:1023];
    logic [15:0]           frozen [0:1023];
    logic                  copied_ok;
    logic                  frozen_ok;
    logic [17:1]           copy_start;
    int                    n_words;
    logic                  took;
    logic                  prev_take;
    logic                  vb_fell;
    // bus and stream as seen at the previous edge
    logic                  prev_cs;
    logic                  prev_ok;
    logic                  prev_vb;
    logic [17:1]           prev_addr;
    logic [15:0]           prev_data;
    logic                  prev_valid;
    logic                  prev_ready;
    logic [15:0]           hx;
    logic [15:0]           hc;
    logic [15:0]           ha;
    logic [obj_line_w-1:0] hr;
    // expected hits of the line being walked, in list order
    logic                  walking;
    logic [obj_line_w-1:0] walk_line;
    int                    line_hits;
    int                    line_exp;
    logic [15:0]           exp_x [$];
    logic [15:0]           exp_code [$];
    logic [15:0]           exp_attr [$];
    logic [obj_line_w-1:0] exp_row [$];

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("at %0t ns: %s", $time, what);
        other_errs++;
    endtask

    // walk the frozen list the way the video chip defines it
    task automatic predict_hits(input logic [obj_line_w-1:0] ln);
        obj_attr_u             attr;
        logic [obj_line_w-1:0] row;
        int                    span;
        exp_x.delete();
        exp_code.delete();
        exp_attr.delete();
        exp_row.delete();
        for (int e = 0; e < entry_limit; e++) begin
            attr = frozen[e * obj_entry_words + 3];
            if (attr.ctl.marker == obj_end_code) begin
                break;
            end
            // row wraps at 512
            row  = ln - frozen[e * obj_entry_words + 1][obj_line_w-1:0];
            span = 16 * (int'(attr.fmt.vsize) + 1);
            if (int'(row) < span) begin
                exp_x.push_back(frozen[e * obj_entry_words]);
                exp_code.push_back(frozen[e * obj_entry_words + 2]);
                exp_attr.push_back(attr);
                exp_row.push_back(row);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            value_errs = 0;
            other_errs = 0;
            objs_seen  = 0;
            copied_ok  = 1'b0;
            frozen_ok  = 1'b0;
            walking    = 1'b0;
            vb_fell    = 1'b0;
            prev_take  = 1'b0;
            n_words    = 0;
            if (vram_cs || obj_valid || line_done) begin
                report_fault("vram_cs, obj_valid or line_done high during reset");
            end
        end else begin
            if (prev_vb && !vb) begin
                vb_fell = 1'b1;
            end
            // address moved, so the previous cycle took a word
            took = prev_cs && (vram_addr != prev_addr);
            if (took) begin
                if (!prev_ok) begin
                    report_fault("VRAM word taken while vram_ok was low");
                end
                if (prev_take) begin
                    report_fault("VRAM words taken with no wait cycle between them");
                end
                compare_field("vram_addr", 32'(copy_start + 17'(n_words)), 32'(prev_addr));
                if (n_words < 1024) begin
                    capt[n_words] = prev_data;
                end
                n_words++;
            end
            prev_take = took;
            if (prev_cs && !vram_cs) begin
                compare_field("copied_words", 1024, n_words);
                copied    = capt;
                copied_ok = 1'b1;
            end
            // new copy: banks swap, last copy becomes the walked list
            if (!prev_cs && vram_cs) begin
                if (!vb_fell) begin
                    report_fault("copy started without vb falling first");
                end
                vb_fell    = 1'b0;
                frozen     = copied;
                frozen_ok  = copied_ok;
                n_words    = 0;
                prev_take  = 1'b1;
                // base word address, bits 9..1 moved up by 8
                copy_start = 17'(vram_base[9:1]) << 8;
                compare_field("vram_addr", 32'(copy_start), 32'(vram_addr));
            end
            // held object under back-pressure
            if (prev_valid && !prev_ready) begin
                if (!obj_valid || obj_x !== hx || obj_code !== hc || obj_attr !== ha
                        || obj_row !== hr) begin
                    report_fault("presented object changed or dropped before obj_ready");
                end
            end
            if (obj_valid && obj_ready) begin
                objs_seen++;
                line_hits++;
                if (exp_x.size() == 0) begin
                    report_fault($sformatf("extra object on line %0d", walk_line));
                end else begin
                    compare_field("obj_x", exp_x.pop_front(), obj_x);
                    compare_field("obj_code", exp_code.pop_front(), obj_code);
                    compare_field("obj_attr", exp_attr.pop_front(), obj_attr);
                    compare_field("obj_row", exp_row.pop_front(), obj_row);
                end
            end
            if (line_done) begin
                if (obj_valid) begin
                    report_fault("line_done while an object is still presented");
                end
                if (!walking) begin
                    report_fault("line_done without a line walk");
                end
                compare_field("line_hits", line_exp, line_hits);
                walking = 1'b0;
            end
            if (line_start && !walking) begin
                if (!frozen_ok) begin
                    report_fault("line walked before any list was copied");
                end
                walking   = 1'b1;
                walk_line = line;
                line_hits = 0;
                predict_hits(line);
                line_exp  = exp_x.size();
            end
        end
        prev_cs    = vram_cs;
        prev_ok    = vram_ok;
        prev_vb    = vb;
        prev_addr  = vram_addr;
        prev_data  = vram_data;
        prev_valid = obj_valid;
        prev_ready = obj_ready;
        hx         = obj_x;
        hc         = obj_code;
        ha         = obj_attr;
        hr         = obj_row;
    end

endmodule

`default_nettype wire

// ==== sim/obj_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_tb
    import obj_pkg::*;
();

    localparam int clk_period  = 100;
    localparam int table_aw    = 10;
    localparam int entry_limit = 256;
    localparam int list_words  = 1024;
    localparam int n_rows      = 6;
    // per frame a copy of 6 cycles a word, three walks of 10 cycles an entry
    localparam int run_limit   = 2 * n_rows * (list_words * 6 + 3 * entry_limit * 10);

    logic                  clk;
    logic                  rst;
    logic                  vb;
    logic                  line_start;
    logic [obj_line_w-1:0] line;
    logic [15:0]           vram_base;
    logic [15:0]           vram_data;
    logic                  vram_ok;
    logic                  vram_cs;
    logic [17:1]           vram_addr;
    logic                  obj_valid;
    logic                  obj_ready;
    logic [15:0]           obj_x;
    logic [15:0]           obj_code;
    logic [15:0]           obj_attr;
    logic [obj_line_w-1:0] obj_row;
    logic                  line_done;
    int                    value_errs;
    int                    other_errs;
    int                    objs_seen;

    // one row per frame: y and vsize of entries 0..5, marker entry, lines
    // marker at entry_limit leaves the list open
    // lines of frame k walk the list copied in frame k-1
    int tbl_y [n_rows][6] = '{
        '{10, 40, 100, 200, 300, 500}, '{20, 20, 60, 480, 0, 130},
        '{7, 7, 7, 7, 7, 7}, '{0, 64, 128, 192, 256, 320},
        '{140, 0, 150, 300, 310, 150}, '{5, 50, 95, 140, 185, 230}
    };
    int tbl_vsize [n_rows][6] = '{
        '{0, 1, 3, 0, 15, 2}, '{1, 0, 2, 3, 0, 7}, '{15, 15, 15, 15, 15, 15},
        '{3, 3, 3, 3, 3, 3}, '{0, 8, 15, 1, 0, 3}, '{1, 1, 1, 1, 1, 1}
    };
    int tbl_mark [n_rows] = '{6, 3, 0, entry_limit, 5, 6};
    int tbl_line [n_rows][3] = '{
        '{0, 0, 0}, '{15, 45, 505}, '{25, 70, 490},
        '{0, 100, 300}, '{2, 150, 400}, '{150, 311, 160}
    };

    // VRAM image of the current frame and its answer delay
    logic [15:0]           vram_img [0:list_words-1];
    logic [17:1]           req_addr;
    logic                  req_live;
    int                    ok_delay;
    int                    ready_low;

    obj_top #(
        .table_aw    (table_aw),
        .entry_limit (entry_limit)
    ) dut_i (.*);

    obj_checker #(
        .entry_limit (entry_limit)
    ) chk_i (.*);

    // background words, attribute words kept below the marker value
    function automatic logic [15:0] fill_word(input int a, input int r);
        logic [15:0] w;
        w = 16'(a * 40503 + r * 977 + 965);
        if (a % obj_entry_words == 3) begin
            w[15] = 1'b0;
        end
        return w;
    endfunction

    task automatic load_frame(input int r);
        obj_attr_u attr;
        for (int a = 0; a < list_words; a++) begin
            vram_img[a] = fill_word(a, r);
        end
        for (int e = 0; e < 6; e++) begin
            attr.fmt.vsize      = 4'(tbl_vsize[r][e]);
            attr.fmt.hsize      = 4'(e);
            attr.fmt.rsvd       = 1'b0;
            attr.fmt.flipy      = 1'(e);
            attr.fmt.flipx      = 1'(r);
            attr.fmt.palette    = 5'(r * 6 + e);
            vram_img[4 * e]     = 16'(16 * e + 100 * r + 7);
            vram_img[4 * e + 1] = 16'(tbl_y[r][e]);
            vram_img[4 * e + 2] = 16'(2048 + 16 * r + e);
            vram_img[4 * e + 3] = attr;
        end
        if (tbl_mark[r] < entry_limit) begin
            attr.ctl.marker = obj_end_code;
            attr.ctl.dc     = 8'(r);
            vram_img[4 * tbl_mark[r] + 3] = attr;
        end
    endtask

    task automatic scan_line(input int ln);
        @(negedge clk);
        line       = obj_line_w'(ln);
        line_start = 1'b1;
        @(negedge clk);
        line_start = 1'b0;
        while (!line_done) begin
            @(negedge clk);
        end
    endtask

    task automatic run_frame(input int r);
        load_frame(r);
        @(negedge clk);
        vb = 1'b0;
        while (!vram_cs) begin
            @(negedge clk);
        end
        while (vram_cs) begin
            @(negedge clk);
        end
        // read bank holds no list until the second frame
        if (r > 0) begin
            for (int i = 0; i < 3; i++) begin
                scan_line(tbl_line[r][i]);
            end
        end
        @(negedge clk);
        vb = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // VRAM answers 0 to 3 cycles after a new address, ready drops 0 to 2 cycles
    initial begin
        void'($urandom(62782));
        vram_ok   = 1'b0;
        vram_data = '0;
        obj_ready = 1'b0;
        req_live  = 1'b0;
        ok_delay  = 0;
        ready_low = 0;
        forever begin
            @(negedge clk);
            if (!vram_cs) begin
                req_live = 1'b0;
                vram_ok  = 1'b0;
            end else if (!req_live || vram_addr != req_addr) begin
                req_live = 1'b1;
                req_addr = vram_addr;
                ok_delay = $urandom % 4;
                vram_ok  = (ok_delay == 0);
            end else if (ok_delay > 0) begin
                ok_delay = ok_delay - 1;
                vram_ok  = (ok_delay == 0);
            end
            vram_data = vram_img[10'(vram_addr - {vram_base[9:1], 8'd0})];
            if (ready_low > 0) begin
                obj_ready = 1'b0;
                ready_low = ready_low - 1;
            end else begin
                obj_ready = 1'b1;
                ready_low = $urandom % 3;
            end
        end
    end

    initial begin
        rst        = 1'b1;
        vb         = 1'b1;
        line_start = 1'b0;
        line       = '0;
        vram_base  = 16'h0246;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // blanking holds a while, no copy yet
        repeat (6) @(negedge clk);
        for (int r = 0; r < n_rows; r++) begin
            run_frame(r);
        end
        repeat (4) @(negedge clk);
        $display("summary: %0d value errors, %0d other errors, %0d objects transferred",
                 value_errs, other_errs, objs_seen);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(run_limit * clk_period);
        $display("timeout: run did not finish within %0d clock cycles", run_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/obj_pkg.sv
src/obj_table.sv
src/obj_line_scan.sv
src/obj_top.sv
sim/obj_checker.sv
sim/obj_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the obj_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module obj_tb -Mdir obj_build -o obj_sim -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_build/obj_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the log decides the result
if grep -F -q "*** TEST PASSED ***" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
